/* src/cop_isa_pkg.sv */
package cop_isa_pkg;

    // Instruction field positions
    localparam int OP_LSB   = 28;
    localparam int OP_W     = 4;
    localparam int CRD_LSB  = 24;
    localparam int CRS1_LSB = 20;
    localparam int CRS2_LSB = 16;
    localparam int CRS3_LSB = 12;
    localparam int REG_W    = 4;
    localparam int IMM_LSB  = 0;
    localparam int IMM_W    = 6;

    localparam int NUM_CPR  = 16;   // Size of the coprocessor register file

    typedef logic [REG_W-1:0] cpr_addr_t;
    typedef logic [IMM_W-1:0] imm_t;

    // Multi-precision opcodes, 11 to 15 are illegal
    typedef enum logic [OP_W-1:0] {
        ADD2 = 4'd0,
        ADD3 = 4'd1,
        SUB2 = 4'd2,
        SUB3 = 4'd3,
        ACC1 = 4'd4,
        ACC2 = 4'd5,
        MAC  = 4'd6,
        SLL  = 4'd7,
        SLLI = 4'd8,
        SRL  = 4'd9,
        SRLI = 4'd10
    } mp_op_e;

    localparam mp_op_e OP_LAST = SRLI;  // Highest legal code

    // Decoded instruction as held during execution
    typedef struct packed {
        mp_op_e    op;
        cpr_addr_t crd;
        cpr_addr_t crs1;
        cpr_addr_t crs2;
        cpr_addr_t crs3;
        imm_t      imm;
    } mp_instr_t;

endpackage

/* src/cop_dp_pkg.sv */
package cop_dp_pkg;

    import cop_isa_pkg::*;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [2*XLEN-1:0] dword_t;
    typedef logic [XLEN/8-1:0] ben_t;      // One enable per byte

    // Register file write request
    typedef struct packed {
        logic      en;
        ben_t      ben;
        cpr_addr_t addr;
        word_t     data;
    } cpr_wr_t;

    // ALU sequencing steps
    typedef enum logic [1:0] {
        STEP0,
        STEP1,
        STEP2,
        STEP3
    } malu_step_e;

endpackage

/* src/cop_issue.sv */
module cop_issue
    import cop_isa_pkg::*, cop_dp_pkg::*;
(
    input  logic      g_clk,
    input  logic      g_resetn,

    input  logic      instr_valid,
    input  word_t     instr,
    output logic      instr_ready,
    output logic      instr_done,
    output logic      instr_illegal,

    output logic      malu_ivalid,
    output mp_instr_t malu_instr,
    input  logic      malu_idone,
    input  logic      malu_rdm_in_rs,
    input  ben_t      malu_ben,
    input  word_t     malu_wdata,

    output cpr_addr_t rd_addr1,
    output cpr_addr_t rd_addr2,
    output cpr_addr_t rd_addr3,
    output cpr_wr_t   malu_wr
);

    logic      busy_q;
    logic      illegal_q;
    logic      wr_hi_q;     // Next writeback targets the odd register
    mp_instr_t instr_q;
    mp_instr_t instr_dec;
    logic      accept;
    logic      wb_en;
    cpr_addr_t rd_even;
    cpr_addr_t rd_odd;

    assign instr_ready = !busy_q;
    assign accept      = instr_valid && instr_ready;

    // Split the raw word into its fields
    always_comb begin
        instr_dec.op   = mp_op_e'(instr[OP_LSB +: OP_W]);
        instr_dec.crd  = instr[CRD_LSB +: REG_W];
        instr_dec.crs1 = instr[CRS1_LSB +: REG_W];
        instr_dec.crs2 = instr[CRS2_LSB +: REG_W];
        instr_dec.crs3 = instr[CRS3_LSB +: REG_W];
        instr_dec.imm  = instr[IMM_LSB +: IMM_W];
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            busy_q    <= 1'b0;
            illegal_q <= 1'b0;
        end else if (accept) begin
            busy_q    <= 1'b1;
            illegal_q <= instr_dec.op > OP_LAST;   // Unknown code, finish at once
        end else if (instr_done) begin
            busy_q    <= 1'b0;
            illegal_q <= 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            instr_q <= instr_dec;
        end
    end

    // Low word comes first, then high word
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            wr_hi_q <= 1'b0;
        end else if (accept) begin
            wr_hi_q <= 1'b0;
        end else if (wb_en) begin
            wr_hi_q <= !wr_hi_q;
        end
    end

    assign malu_ivalid   = busy_q && !illegal_q;
    assign malu_instr    = instr_q;
    assign instr_done    = busy_q && (illegal_q || malu_idone);
    assign instr_illegal = busy_q && illegal_q;

    // Destination register pair
    assign rd_even = {instr_q.crd[REG_W-1:1], 1'b0};
    assign rd_odd  = {instr_q.crd[REG_W-1:1], 1'b1};

    // Accumulates fetch the destination pair on ports 2 and 3
    assign rd_addr1 = instr_q.crs1;
    assign rd_addr2 = malu_rdm_in_rs ? rd_even : instr_q.crs2;
    assign rd_addr3 = malu_rdm_in_rs ? rd_odd  : instr_q.crs3;

    assign wb_en = |malu_ben;

    always_comb begin
        malu_wr.en   = wb_en;
        malu_wr.ben  = malu_ben;
        malu_wr.addr = wr_hi_q ? rd_odd : rd_even;
        malu_wr.data = malu_wdata;
    end

endmodule

/* src/cop_cpr.sv */
module cop_cpr
    import cop_isa_pkg::*, cop_dp_pkg::*;
(
    input  logic      g_clk,
    input  logic      g_resetn,

    input  cpr_addr_t rd_addr1,
    input  cpr_addr_t rd_addr2,
    input  cpr_addr_t rd_addr3,
    input  cpr_addr_t host_raddr,
    output word_t     rd_data1,
    output word_t     rd_data2,
    output word_t     rd_data3,
    output word_t     host_rdata,

    input  cpr_wr_t   malu_wr,
    input  cpr_wr_t   host_wr
);

    word_t   cpr_q [NUM_CPR];
    cpr_wr_t wr;

    // Single write port, ALU wins over host
    assign wr = malu_wr.en ? malu_wr : host_wr;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < NUM_CPR; i++) begin
                cpr_q[i] <= '0;
            end
        end else if (wr.en) begin
            for (int b = 0; b < XLEN/8; b++) begin
                if (wr.ben[b]) begin
                    cpr_q[wr.addr][8*b +: 8] <= wr.data[8*b +: 8];
                end
            end
        end
    end

    // Combinational reads see the value before this cycle's write
    assign rd_data1   = cpr_q[rd_addr1];
    assign rd_data2   = cpr_q[rd_addr2];
    assign rd_data3   = cpr_q[rd_addr3];
    assign host_rdata = cpr_q[host_raddr];

endmodule

/* src/cop_malu.sv */
module cop_malu
    import cop_isa_pkg::*, cop_dp_pkg::*;
(
    input  logic      g_clk,
    input  logic      g_resetn,

    input  logic      malu_ivalid,
    output logic      malu_idone,
    output logic      malu_rdm_in_rs,   // Ports 2 and 3 carry the destination pair

    input  mp_instr_t malu_instr,
    input  word_t     malu_rs1,
    input  word_t     malu_rs2,
    input  word_t     malu_rs3,

    output ben_t      malu_ben,
    output word_t     malu_wdata
);

    malu_step_e step_q;
    malu_step_e step_nxt;
    dword_t     tmp_q;
    dword_t     tmp_nxt;

    logic is_add2, is_add3, is_sub2, is_sub3;
    logic is_acc1, is_acc2, is_mac;
    logic is_sll, is_slli, is_srl, is_srli;
    logic is_shf, two_step, three_step;
    logic st0, st1, st2;
    logic tmp_ld;
    logic wb_lo, wb_hi;

    dword_t add_lhs, add_rhs, add_res;
    dword_t mul_res;
    dword_t shf_src, shf_res;
    logic   do_sub;
    logic   shf_right;
    imm_t   shamt;

    // Per-opcode decode
    assign is_add2 = malu_ivalid && malu_instr.op == ADD2;
    assign is_add3 = malu_ivalid && malu_instr.op == ADD3;
    assign is_sub2 = malu_ivalid && malu_instr.op == SUB2;
    assign is_sub3 = malu_ivalid && malu_instr.op == SUB3;
    assign is_acc1 = malu_ivalid && malu_instr.op == ACC1;
    assign is_acc2 = malu_ivalid && malu_instr.op == ACC2;
    assign is_mac  = malu_ivalid && malu_instr.op == MAC;
    assign is_sll  = malu_ivalid && malu_instr.op == SLL;
    assign is_slli = malu_ivalid && malu_instr.op == SLLI;
    assign is_srl  = malu_ivalid && malu_instr.op == SRL;
    assign is_srli = malu_ivalid && malu_instr.op == SRLI;

    assign is_shf     = is_sll || is_slli || is_srl || is_srli;
    assign two_step   = is_add2 || is_sub2 || is_acc1 || is_shf;
    assign three_step = is_add3 || is_sub3 || is_acc2 || is_mac;

    assign st0 = step_q == STEP0;
    assign st1 = step_q == STEP1;
    assign st2 = step_q == STEP2;

    always_comb begin
        unique case (step_q)
            STEP0:   step_nxt = STEP1;
            STEP1:   step_nxt = STEP2;
            STEP2:   step_nxt = STEP3;
            default: step_nxt = STEP0;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            step_q <= STEP0;
        end else if (malu_idone) begin
            step_q <= STEP0;        // Ready for the next instruction
        end else if (malu_ivalid) begin
            step_q <= step_nxt;
        end
    end

    assign malu_idone     = (st1 && two_step) || (st2 && three_step);
    assign malu_rdm_in_rs = st0 && (is_acc1 || is_acc2);

    // Shared 64-bit adder
    // Step 0 starts from rs1, later steps add onto tmp
    always_comb begin
        if (st0) begin
            add_lhs = {32'b0, malu_rs1};
            if (is_acc1 || is_acc2) begin
                add_rhs = {malu_rs3, malu_rs2};    // Destination pair, odd word high
            end else begin
                add_rhs = {32'b0, malu_rs2};
            end
        end else begin
            add_lhs = tmp_q;
            add_rhs = {32'b0, is_acc2 ? malu_rs2 : malu_rs3};
        end
    end

    assign do_sub  = is_sub2 || is_sub3;
    assign add_res = do_sub ? add_lhs - add_rhs : add_lhs + add_rhs;

    // 32x32 multiplier, full product
    assign mul_res = {32'b0, malu_rs1} * {32'b0, malu_rs2};

    // Funnel shifter over {rs1,rs2}
    assign shf_right = is_srl || is_srli;
    assign shamt     = (is_slli || is_srli) ? malu_instr.imm : malu_rs3[IMM_W-1:0];
    assign shf_src   = {malu_rs1, malu_rs2};
    assign shf_res   = shf_right ? shf_src >> shamt : shf_src << shamt;

    // Partial result register
    assign tmp_ld = (st0 && (two_step || three_step)) || (st1 && three_step);

    always_comb begin
        if (st0 && is_mac) begin
            tmp_nxt = mul_res;
        end else if (is_shf) begin
            tmp_nxt = shf_res;
        end else begin
            tmp_nxt = add_res;
        end
    end

    always_ff @(posedge g_clk) begin
        if (tmp_ld) begin
            tmp_q <= tmp_nxt;
        end
    end

    // Low word one step before the end, high word from tmp in the last step
    assign wb_lo = (st0 && two_step) || (st1 && three_step);
    assign wb_hi = malu_idone;

    assign malu_ben = {$bits(ben_t){wb_lo || wb_hi}};

    always_comb begin
        if (wb_hi) begin
            malu_wdata = tmp_q[63:32];
        end else if (wb_lo) begin
            malu_wdata = is_shf ? shf_res[31:0] : add_res[31:0];
        end else begin
            malu_wdata = '0;
        end
    end

endmodule

/* src/cop_top.sv */
module cop_top
    import cop_isa_pkg::*, cop_dp_pkg::*;
(
    input  logic      g_clk,
    input  logic      g_resetn,

    // Instruction issue
    input  logic      instr_valid,
    input  word_t     instr,
    output logic      instr_ready,
    output logic      instr_done,
    output logic      instr_illegal,

    // Host access to the register file
    input  cpr_wr_t   host_wr,
    input  cpr_addr_t host_raddr,
    output word_t     host_rdata
);

    logic      malu_ivalid;
    logic      malu_idone;
    logic      malu_rdm_in_rs;
    mp_instr_t malu_instr;
    ben_t      malu_ben;
    word_t     malu_wdata;
    cpr_wr_t   malu_wr;

    cpr_addr_t rd_addr1, rd_addr2, rd_addr3;
    word_t     rd_data1, rd_data2, rd_data3;

    cop_issue issue_i (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .instr_ready    (instr_ready),
        .instr_done     (instr_done),
        .instr_illegal  (instr_illegal),
        .malu_ivalid    (malu_ivalid),
        .malu_instr     (malu_instr),
        .malu_idone     (malu_idone),
        .malu_rdm_in_rs (malu_rdm_in_rs),
        .malu_ben       (malu_ben),
        .malu_wdata     (malu_wdata),
        .rd_addr1       (rd_addr1),
        .rd_addr2       (rd_addr2),
        .rd_addr3       (rd_addr3),
        .malu_wr        (malu_wr)
    );

    cop_cpr cpr_i (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .rd_addr1   (rd_addr1),
        .rd_addr2   (rd_addr2),
        .rd_addr3   (rd_addr3),
        .host_raddr (host_raddr),
        .rd_data1   (rd_data1),
        .rd_data2   (rd_data2),
        .rd_data3   (rd_data3),
        .host_rdata (host_rdata),
        .malu_wr    (malu_wr),
        .host_wr    (host_wr)
    );

    cop_malu malu_i (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .malu_ivalid    (malu_ivalid),
        .malu_idone     (malu_idone),
        .malu_rdm_in_rs (malu_rdm_in_rs),
        .malu_instr     (malu_instr),
        .malu_rs1       (rd_data1),
        .malu_rs2       (rd_data2),
        .malu_rs3       (rd_data3),
        .malu_ben       (malu_ben),
        .malu_wdata     (malu_wdata)
    );

endmodule

/* dv/cop_properties.sv */
module cop_properties
    import cop_dp_pkg::*;
(
    input logic    g_clk,
    input logic    g_resetn,
    input logic    instr_valid,
    input logic    instr_ready,
    input logic    instr_done,
    input logic    instr_illegal,
    input logic    busy_q,
    input cpr_wr_t malu_wr
);
    timeunit 1ns;
    timeprecision 1ps;

    logic accept;

    assign accept = instr_valid && instr_ready;

    // Ready comes back the cycle after done
    done_then_ready: assert property (@(posedge g_clk) disable iff (!g_resetn)
        instr_done |=> instr_ready) else $error("instr_ready not restored after instr_done");

    // Illegal code ends one cycle after acceptance and writes nothing
    illegal_with_done: assert property (@(posedge g_clk) disable iff (!g_resetn)
        instr_illegal |-> instr_done && $past(accept) && !malu_wr.en)
        else $error("instr_illegal outside the cycle after acceptance");

    // Ready drops after acceptance and stays low until the done cycle
    accept_drops_ready: assert property (@(posedge g_clk) disable iff (!g_resetn)
        accept |=> !instr_ready) else $error("instr_ready high after acceptance");

    busy_holds_ready: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (!instr_ready && !instr_done) |=> !instr_ready) else $error("instr_ready rose early");

    wr_only_busy: assert property (@(posedge g_clk) disable iff (!g_resetn)
        malu_wr.en |-> busy_q) else $error("ALU write while idle");

    // Low word before the done cycle, high word in it
    wr_pair_order: assert property (@(posedge g_clk) disable iff (!g_resetn)
        malu_wr.en |-> &malu_wr.ben && (malu_wr.addr[0] == instr_done))
        else $error("ALU write with partial byte enable or out of order");

endmodule

bind cop_issue cop_properties props_i (
    .g_clk         (g_clk),
    .g_resetn      (g_resetn),
    .instr_valid   (instr_valid),
    .instr_ready   (instr_ready),
    .instr_done    (instr_done),
    .instr_illegal (instr_illegal),
    .busy_q        (busy_q),
    .malu_wr       (malu_wr)
);

/* dv/cop_tb.sv */
module cop_tb
    import cop_isa_pkg::*, cop_dp_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RST_CYCLES = 16;
    localparam int N_HOST     = 64;
    localparam int N_RAND     = 400;
    localparam int N_ILLEGAL  = 20;
    localparam int N_B2B      = 40;
    localparam int DONE_LIMIT = 8;     // Cycles allowed for one instruction
    // Reset, host phase, instructions with register scans, queue, margin
    localparam int WD_CYCLES  = RST_CYCLES + 6 * 16 + N_HOST
                              + (N_RAND + N_ILLEGAL) * (5 + 16) + N_B2B * 5 + 500;

    logic      g_clk;
    logic      g_resetn;
    logic      instr_valid;
    word_t     instr;
    logic      instr_ready;
    logic      instr_done;
    logic      instr_illegal;
    cpr_wr_t   host_wr;
    cpr_addr_t host_raddr;
    word_t     host_rdata;

    word_t model [16];     // Expected register file
    int    err_cnt = 0;
    int    chk_cnt = 0;

    cop_top dut_i (.*);

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge g_clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    task automatic next_cycle();
        @(posedge g_clk);
        #2;
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic host_write(input cpr_addr_t addr, input ben_t ben, input word_t data);
        host_wr.en   = 1'b1;
        host_wr.ben  = ben;
        host_wr.addr = addr;
        host_wr.data = data;
        for (int b = 0; b < 4; b++) begin
            if (ben[b]) model[addr][8*b +: 8] = data[8*b +: 8];
        end
        next_cycle();
        host_wr.en = 1'b0;
    endtask

    // One host read per cycle, address held across the edge
    task automatic check_all_regs();
        for (int i = 0; i < 16; i++) begin
            host_raddr = cpr_addr_t'(i);
            next_cycle();
            check_value($sformatf("host_rdata[%0d]", i), 64'(model[i]), 64'(host_rdata));
        end
    endtask

    function automatic dword_t expected_pair(input logic [3:0] op, input logic [3:0] crd,
        input logic [3:0] crs1, input logic [3:0] crs2, input logic [3:0] crs3,
        input logic [5:0] imm);
        dword_t a;
        dword_t b;
        dword_t c;
        dword_t p;
        dword_t cat;
        a   = {32'b0, model[crs1]};
        b   = {32'b0, model[crs2]};
        c   = {32'b0, model[crs3]};
        p   = {model[{crd[3:1], 1'b1}], model[{crd[3:1], 1'b0}]};
        cat = {model[crs1], model[crs2]};
        case (op)
            4'd0:    return a + b;
            4'd1:    return a + b + c;
            4'd2:    return a - b;
            4'd3:    return a - b - c;
            4'd4:    return p + a;
            4'd5:    return p + a + b;
            4'd6:    return a * b + c;
            4'd7:    return cat << c[5:0];
            4'd8:    return cat << imm;
            4'd9:    return cat >> c[5:0];
            default: return cat >> imm;
        endcase
    endfunction

    function automatic word_t random_instr(input logic [3:0] op);
        word_t       w;
        logic [31:0] r;
        w = $urandom;
        r = $urandom;
        w[31:28] = op;
        if (r[1:0] == 2'b00) w[23:20] = w[27:24] ^ 4'd1;   // Source inside the dest pair
        if (r[3:2] == 2'b00) w[15:12] = w[27:24];
        return w;
    endfunction

    task automatic issue_instr(input word_t w, input bit hold_valid);
        int     cyc;
        int     exp_lat;
        dword_t res;
        instr       = w;
        instr_valid = 1'b1;
        cyc = 0;
        while (!instr_ready && cyc < DONE_LIMIT) begin
            next_cycle();
            cyc++;
        end
        if (!instr_ready) begin
            $display("Timeout: instr_ready stayed low before issuing %h", w);
            err_cnt++;
            return;
        end
        if (w[31:28] > 4'd10) exp_lat = 1;
        else if (w[31:28] inside {4'd1, 4'd3, 4'd5, 4'd6}) exp_lat = 3;
        else exp_lat = 2;
        res = expected_pair(w[31:28], w[27:24], w[23:20], w[19:16], w[15:12], w[5:0]);
        next_cycle();                             // Accepting edge
        if (!hold_valid) instr_valid = 1'b0;
        check_value("instr_ready", 64'(0), 64'(instr_ready));
        cyc = 1;
        while (!instr_done && cyc < DONE_LIMIT) begin
            next_cycle();
            cyc++;
        end
        if (!instr_done) begin
            $display("Timeout: no instr_done for instruction %h", w);
            err_cnt++;
            return;
        end
        check_value("instr_done latency", 64'(exp_lat), 64'(cyc));
        check_value("instr_illegal", 64'(exp_lat == 1), 64'(instr_illegal));
        if (exp_lat != 1) begin
            model[{w[27:25], 1'b0}] = res[31:0];
            model[{w[27:25], 1'b1}] = res[63:32];
        end
        next_cycle();
        check_value("instr_ready", 64'(1), 64'(instr_ready));
        check_value("instr_done", 64'(0), 64'(instr_done));
    endtask

    initial begin
        logic [31:0] r;
        g_resetn    = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        host_wr     = '0;
        host_raddr  = '0;
        for (int i = 0; i < 16; i++) model[i] = '0;
        void'($urandom(32'h2166));
        repeat (RST_CYCLES) @(posedge g_clk);
        #2;
        g_resetn = 1'b1;
        check_value("instr_ready", 64'(1), 64'(instr_ready));
        check_value("instr_done", 64'(0), 64'(instr_done));
        check_all_regs();
        for (int i = 0; i < 16; i++) host_write(cpr_addr_t'(i), 4'hf, $urandom);
        check_all_regs();
        for (int i = 0; i < N_HOST; i++) begin
            r = $urandom;
            host_write(r[3:0], r[7:4], $urandom);   // Partial byte enables
        end
        check_all_regs();
        for (int i = 0; i < N_RAND; i++) begin
            r = $urandom_range(0, 10);
            issue_instr(random_instr(r[3:0]), 1'b0);
            check_all_regs();
        end
        for (int i = 0; i < N_ILLEGAL; i++) begin
            r = $urandom_range(11, 15);
            issue_instr(random_instr(r[3:0]), 1'b0);
            check_all_regs();
        end
        for (int i = 0; i < N_B2B; i++) begin
            r = $urandom_range(0, 10);
            issue_instr(random_instr(r[3:0]), 1'b1);   // Valid held for the queue
        end
        instr_valid = 1'b0;
        check_all_regs();
        $display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
src/cop_isa_pkg.sv
src/cop_dp_pkg.sv
src/cop_issue.sv
src/cop_cpr.sv
src/cop_malu.sv
src/cop_top.sv
dv/cop_properties.sv
dv/cop_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module cop_tb -f compile.f -o cop_sim \
    && ./obj_dir/cop_sim > sim.log 2>&1 \
    || { echo "Build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "TEST OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
